// ==== dv/rvv_checker.sv ====
`include "rvv_settings.svh"

module rvv_checker (
	input  logic        clk,
	input  logic        resetn,
	input  logic        pcpi_valid_i,
	input  logic        pcpi_wait_i,
	input  logic        pcpi_ready_i,
	input  logic        pcpi_wr_i,
	input  logic [31:0] pcpi_rd_i,
	input  logic        mem_valid_i,
	input  logic        mem_we_i,
	input  logic [31:0] mem_addr_i,
	input  logic [31:0] mem_wdata_i,
	input  logic [3:0]  mem_strb_i,
	input  logic        mem_done_i,
	input  logic        exp_wr_i,
	input  logic [31:0] exp_rd_i,
	input  logic        exp_we_i,
	input  int          exp_beats_i,
	input  int          exp_lat_i,
	input  logic [31:0] exp_base_i,
	input  int          exp_ebytes_i,
	input  logic [7:0]  exp_bytes_i [`RVV_VLEN],
	output int          errors_o,
	output int          checks_o
);
	timeunit 1ns;
	timeprecision 1ps;

	int lat;   // cycles with valid high before ready
	int beats; // memory handshakes of the running instruction

	task automatic mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
		errors_o++;
		$display("MISMATCH t=%0t %s got %h expected %h", $time, sig, got, exp);
	endtask

	// address and direction of every beat, strobe and bytes of stores
	task automatic check_beat();
		logic [31:0] addr_exp;
		logic [3:0] strb_exp;
		int lane;
		int pos;
		addr_exp = exp_base_i + 32'(beats * exp_ebytes_i);
		lane = int'(addr_exp[1:0]);
		for (int k = 0; k < 4; k++)
			strb_exp[k] = k >= lane && k < lane + exp_ebytes_i;
		checks_o++;
		if (mem_addr_i !== addr_exp)
			mismatch("mem_addr_o", mem_addr_i, addr_exp);
		if (mem_we_i !== exp_we_i)
			mismatch("mem_we_o", {31'b0, mem_we_i}, {31'b0, exp_we_i});
		if (exp_we_i) begin
			if (mem_strb_i !== strb_exp)
				mismatch("mem_strb_o", {28'b0, mem_strb_i}, {28'b0, strb_exp});
			for (int k = 0; k < 4; k++) begin
				pos = beats * exp_ebytes_i - lane + k; // byte offset from base
				if (strb_exp[k] && pos < `RVV_VLEN
						&& mem_wdata_i[k * 8 +: 8] !== exp_bytes_i[pos])
					mismatch("mem_wdata_o byte", {24'b0, mem_wdata_i[k * 8 +: 8]},
						{24'b0, exp_bytes_i[pos]});
			end
		end
	endtask

	initial begin
		errors_o = 0;
		checks_o = 0;
		lat = 0;
		beats = 0;
	end

	always @(posedge clk) begin
		if (!resetn) begin
			lat = 0;
			beats = 0;
		end else begin
			if (mem_valid_i && mem_done_i) begin
				check_beat();
				beats++;
			end
			if (pcpi_ready_i) begin
				checks_o++;
				if (pcpi_wr_i !== exp_wr_i)
					mismatch("pcpi_wr_o", {31'b0, pcpi_wr_i}, {31'b0, exp_wr_i});
				if (exp_wr_i && pcpi_rd_i !== exp_rd_i)
					mismatch("pcpi_rd_o", pcpi_rd_i, exp_rd_i);
				if (beats != exp_beats_i)
					mismatch("mem_valid_o requests", beats, exp_beats_i);
				if (exp_lat_i != 0 && lat != exp_lat_i)
					mismatch("pcpi_ready_o latency", lat, exp_lat_i);
				lat = 0;
				beats = 0;
			end else if (pcpi_valid_i) begin
				// wait is due from the second cycle of valid
				if (lat > 0 && pcpi_wait_i !== 1'b1)
					mismatch("pcpi_wait_o", {31'b0, pcpi_wait_i}, 32'd1);
				lat++;
			end else if (pcpi_wait_i !== 1'b0) begin
				mismatch("pcpi_wait_o", {31'b0, pcpi_wait_i}, 32'd0);
			end
		end
	end
endmodule

// ==== dv/tb_top.sv ====
`include "rvv_settings.svh"

module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int VLENB = `RVV_VLEN / 8;
	localparam logic [6:0] OP_V = `RVV_OP_V;
	localparam logic [6:0] OP_LD = `RVV_OP_LOAD_FP;
	localparam logic [6:0] OP_ST = `RVV_OP_STORE_FP;

	logic clk, resetn;
	logic pcpi_valid;
	logic [31:0] pcpi_insn, pcpi_rs1, pcpi_rs2;
	logic pcpi_wr, pcpi_wait, pcpi_ready;
	logic [31:0] pcpi_rd;
	logic mem_valid, mem_we, mem_done;
	logic [31:0] mem_addr, mem_wdata, mem_rdata;
	logic [3:0] mem_strb;

	// expectations posted for the checker
	logic exp_wr, exp_we;
	logic [31:0] exp_rd, exp_base;
	int exp_beats, exp_lat, exp_ebytes;
	logic [7:0] exp_bytes [`RVV_VLEN];

	logic [7:0] mem [1024];
	logic [7:0] shadow [`RVV_NREGS * VLENB]; // vector registers as flat bytes
	logic [31:0] seed, dly_seed;
	int dly, tb_errors, chk_errors, chk_checks;
	int cur_vl, cur_sew, cur_eb;
	int lmuls [5] = '{0, 1, 2, 3, 5};
	logic [31:0] avls [4] = '{32'd5, 32'd16, 32'd64, 32'd300};

	rvv_coproc uut (
		.clk(clk), .resetn(resetn),
		.pcpi_valid_i(pcpi_valid), .pcpi_insn_i(pcpi_insn),
		.pcpi_rs1_i(pcpi_rs1), .pcpi_rs2_i(pcpi_rs2),
		.pcpi_wr_o(pcpi_wr), .pcpi_rd_o(pcpi_rd),
		.pcpi_wait_o(pcpi_wait), .pcpi_ready_o(pcpi_ready),
		.mem_valid_o(mem_valid), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
		.mem_wdata_o(mem_wdata), .mem_strb_o(mem_strb),
		.mem_rdata_i(mem_rdata), .mem_done_i(mem_done)
	);

	rvv_checker chk (
		.clk(clk), .resetn(resetn),
		.pcpi_valid_i(pcpi_valid), .pcpi_wait_i(pcpi_wait), .pcpi_ready_i(pcpi_ready),
		.pcpi_wr_i(pcpi_wr), .pcpi_rd_i(pcpi_rd),
		.mem_valid_i(mem_valid), .mem_we_i(mem_we), .mem_addr_i(mem_addr),
		.mem_wdata_i(mem_wdata), .mem_strb_i(mem_strb), .mem_done_i(mem_done),
		.exp_wr_i(exp_wr), .exp_rd_i(exp_rd), .exp_we_i(exp_we), .exp_beats_i(exp_beats),
		.exp_lat_i(exp_lat), .exp_base_i(exp_base), .exp_ebytes_i(exp_ebytes),
		.exp_bytes_i(exp_bytes), .errors_o(chk_errors), .checks_o(chk_checks)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// vl = min(avl, vlmax), zero for e64 or fractional lmul
	function automatic logic [31:0] exp_vl(input logic [31:0] avl, input int sew, input int lmul);
		logic [31:0] vlmax;
		if (sew > 2 || lmul > 3)
			return 32'd0;
		vlmax = 32'((VLENB >> sew) << lmul);
		return (avl < vlmax) ? avl : vlmax;
	endfunction

	// element 0 of a register, sign-extended at the current sew
	function automatic logic [31:0] elem0(input int vreg);
		int b;
		b = vreg * VLENB;
		case (cur_eb)
			1: return {{24{shadow[b][7]}}, shadow[b]};
			2: return {{16{shadow[b + 1][7]}}, shadow[b + 1], shadow[b]};
			default: return {shadow[b + 3], shadow[b + 2], shadow[b + 1], shadow[b]};
		endcase
	endfunction

	function automatic logic [31:0] vsetvli_insn(input logic [4:0] rs1, input int sew, input int lmul);
		return {4'b0, 2'b0, 3'(sew), 3'(lmul), rs1, 3'b111, 5'd6, OP_V};
	endfunction

	function automatic logic [31:0] mem_insn(input logic store, input logic [4:0] vreg, input int sew);
		logic [2:0] width;
		width = (sew == 0) ? 3'b000 : (sew == 1) ? 3'b101 : 3'b110;
		return {6'b0, 1'b1, 5'b0, 5'd10, width, vreg, store ? OP_ST : OP_LD};
	endfunction

	function automatic logic [31:0] move_insn(input logic [2:0] f3, input logic [4:0] vd,
			input logic [4:0] src);
		return {6'b010111, 1'b1, 5'b0, src, f3, vd, OP_V};
	endfunction

	// memory with 0..3 cycles of random delay per request
	always @(posedge clk) begin
		int a;
		mem_done <= 1'b0;
		if (mem_valid && !mem_done) begin
			if (dly == 0) begin
				a = {22'b0, mem_addr[9:2], 2'b00};
				mem_done <= 1'b1;
				mem_rdata <= {mem[a + 3], mem[a + 2], mem[a + 1], mem[a]};
				for (int k = 0; k < 4; k++)
					if (mem_we && mem_strb[k])
						mem[a + k] <= mem_wdata[k * 8 +: 8];
				dly_seed = lcg(dly_seed);
				dly = int'(dly_seed[17:16]);
			end else begin
				dly = dly - 1;
			end
		end
	end

	task automatic finish_run();
		$display("checks %0d, mismatches %0d, other errors %0d",
			chk_checks, chk_errors, tb_errors);
		if (chk_errors + tb_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic run_insn(input logic [31:0] insn, input logic [31:0] rs1, input logic [31:0] rs2,
			input logic ewr, input logic [31:0] erd, input int ebeats, input int elat,
			input string what);
		int n;
		@(posedge clk);
		pcpi_insn <= insn;
		pcpi_rs1 <= rs1;
		pcpi_rs2 <= rs2;
		pcpi_valid <= 1'b1;
		exp_wr <= ewr;
		exp_rd <= erd;
		exp_we <= insn[6:0] == OP_ST;
		exp_beats <= ebeats;
		exp_lat <= elat;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!pcpi_ready && n < 2000);
		if (!pcpi_ready) begin
			$display("timeout: %s got no pcpi_ready_o within 2000 cycles", what);
			tb_errors++;
			finish_run();
		end else begin
			pcpi_valid <= 1'b0;
			@(posedge clk);
		end
	endtask

	task automatic set_cfg(input logic [31:0] avl, input int sew, input int lmul);
		run_insn(vsetvli_insn(5'd5, sew, lmul), avl, 32'd0, 1'b1, exp_vl(avl, sew, lmul),
			0, 2, "vsetvli");
		cur_vl = int'(exp_vl(avl, sew, lmul));
		cur_sew = sew;
		cur_eb = 1 << sew;
	endtask

	task automatic load(input int vd, input logic [31:0] base);
		exp_base = base;
		exp_ebytes = cur_eb;
		run_insn(mem_insn(1'b0, 5'(vd), cur_sew), base, 32'd0, 1'b0, 32'd0, cur_vl,
			(cur_vl == 0) ? 2 : 0, "vle");
		for (int b = 0; b < cur_vl * cur_eb; b++)
			shadow[vd * VLENB + b] = mem[(int'(base) + b) % 1024];
	endtask

	// expected store image from the shadow registers
	task automatic exp_mem(input int vs3, input logic [31:0] base);
		for (int b = 0; b < `RVV_VLEN; b++)
			exp_bytes[b] = (b < cur_vl * cur_eb) ? shadow[vs3 * VLENB + b] : 8'h00;
		exp_base = base;
		exp_ebytes = cur_eb;
	endtask

	task automatic store(input int vs3, input logic [31:0] base);
		exp_mem(vs3, base);
		run_insn(mem_insn(1'b1, 5'(vs3), cur_sew), base, 32'd0, 1'b0, 32'd0, cur_vl,
			(cur_vl == 0) ? 2 : 0, "vse");
	endtask

	task automatic move_scalar(input logic [2:0] f3, input int vd, input logic [4:0] src,
			input logic [31:0] rs1);
		logic [31:0] val;
		val = (f3 == 3'b011) ? {{27{src[4]}}, src} : rs1;
		run_insn(move_insn(f3, 5'(vd), src), rs1, 32'd0, 1'b0, 32'd0, 0, 0, "vmv.v.x/i");
		for (int b = 0; b < cur_vl * cur_eb; b++)
			shadow[vd * VLENB + b] = val[(b % cur_eb) * 8 +: 8];
	endtask

	task automatic move_vv(input int vd, input int vs1);
		run_insn(move_insn(3'b000, 5'(vd), 5'(vs1)), 32'd0, 32'd0, 1'b0, 32'd0, 0, 0, "vmv.v.v");
		for (int b = 0; b < cur_vl * cur_eb; b++)
			shadow[vd * VLENB + b] = shadow[vs1 * VLENB + b];
	endtask

	task automatic read_elem0(input int vs2);
		run_insn({6'b010000, 1'b1, 5'(vs2), 5'b0, 3'b010, 5'd6, OP_V}, 32'd0, 32'd0,
			1'b1, elem0(vs2), 0, 2, "vmv.x.s");
	endtask

	initial begin
		int k;
		logic [31:0] avl;
		resetn = 1'b0;
		pcpi_valid = 1'b0;
		pcpi_insn = '0;
		pcpi_rs1 = '0;
		pcpi_rs2 = '0;
		mem_done = 1'b0;
		mem_rdata = '0;
		exp_wr = 1'b0;
		exp_we = 1'b0;
		exp_rd = '0;
		exp_beats = 0;
		exp_lat = 0;
		exp_base = '0;
		exp_ebytes = 1;
		seed = 32'd75;
		dly_seed = 32'd75;
		dly = 0;
		tb_errors = 0;
		for (int i = 0; i < 1024; i++) begin
			seed = lcg(seed);
			mem[i] = seed[23:16];
		end
		for (int i = 0; i < `RVV_NREGS * VLENB; i++)
			shadow[i] = 8'h00;
		repeat (3) @(posedge clk);
		resetn <= 1'b1;

		// vsetvli and vsetvl across sew, lmul and avl
		k = 0;
		for (int s = 0; s < 4; s++)
			foreach (lmuls[l])
				foreach (avls[a]) begin
					if (k % 2 == 1)
						run_insn({7'b1000000, 5'd7, 5'd5, 3'b111, 5'd6, OP_V}, avls[a],
							{26'b0, 3'(s), 3'(lmuls[l])}, 1'b1,
							exp_vl(avls[a], s, lmuls[l]), 0, 2, "vsetvl");
					else
						set_cfg(avls[a], s, lmuls[l]);
					k++;
				end

		// vsetivli and the vlmax form
		run_insn({2'b11, 4'b0, 6'b000000, 5'd7, 3'b111, 5'd6, OP_V}, 32'd0, 32'd0,
			1'b1, exp_vl(32'd7, 0, 0), 0, 2, "vsetivli");
		run_insn({2'b11, 4'b0, 6'b000000, 5'd31, 3'b111, 5'd6, OP_V}, 32'd0, 32'd0,
			1'b1, exp_vl(32'd31, 0, 0), 0, 2, "vsetivli");
		run_insn(vsetvli_insn(5'd0, 2, 1), 32'd0, 32'd0, 1'b1, exp_vl('1, 2, 1), 0, 2,
			"vsetvli vlmax");

		// load then store per sew, random vl
		for (int s = 0; s < 3; s++) begin
			seed = lcg(seed);
			avl = {16'b0, seed[31:16]} % exp_vl('1, s, 1) + 32'd1;
			set_cfg(avl, s, 1);
			load(8, 32'h040);
			store(8, 32'h200 + 32'(s) * 32'h40);
		end

		// splats with a short vl keep the loaded tail
		set_cfg(32'd100, 2, 0);
		load(2, 32'h100);
		set_cfg(32'd2, 2, 0);
		move_scalar(3'b100, 2, 5'd5, 32'h8badf00d);
		set_cfg(32'd100, 2, 0);
		store(2, 32'h2c0);
		set_cfg(32'd100, 1, 0);
		load(4, 32'h120);
		set_cfg(32'd3, 1, 0);
		move_scalar(3'b011, 4, 5'b11101, 32'd0);
		set_cfg(32'd100, 1, 0);
		store(4, 32'h300);

		// group copy and scalar read
		set_cfg(32'd20, 0, 1);
		move_vv(12, 8);
		set_cfg(32'd100, 0, 1);
		store(12, 32'h340);
		read_elem0(8);
		set_cfg(32'd100, 1, 0);
		read_elem0(4);

		// vl=0 memory operations
		set_cfg(32'd0, 0, 0);
		load(16, 32'h380);
		store(16, 32'h380);

		finish_run();
	end
endmodule

// ==== hdl/rvv_coproc.sv ====
module rvv_coproc (
	input  logic        clk,
	input  logic        resetn,
	input  logic        pcpi_valid_i,
	input  logic [31:0] pcpi_insn_i,
	input  logic [31:0] pcpi_rs1_i,
	input  logic [31:0] pcpi_rs2_i,
	output logic        pcpi_wr_o,
	output logic [31:0] pcpi_rd_o,
	output logic        pcpi_wait_o,
	output logic        pcpi_ready_o,
	output logic        mem_valid_o,
	output logic        mem_we_o,
	output logic [31:0] mem_addr_o,
	output logic [31:0] mem_wdata_o,
	output logic [3:0]  mem_strb_o,
	input  logic [31:0] mem_rdata_i,
	input  logic        mem_done_i
);
	logic cfg_start, lsu_start, mv_start;
	logic cfg_done, lsu_done, mv_done;
	logic busy_lsu;
	logic [31:0] vl;
	logic [31:0] mv_rd;
	rvv_pkg::sew_e sew;
	rvv_pkg::lmul_e lmul;

	// register file ports of each unit
	logic [4:0] lsu_raddr, lsu_waddr;
	logic lsu_we;
	rvv_pkg::vreg_t lsu_wdata;
	logic [4:0] mv_raddr_a, mv_raddr_b, mv_waddr;
	logic mv_we;
	rvv_pkg::vreg_t mv_wdata;

	logic [4:0] rf_raddr_a, rf_waddr;
	logic rf_we;
	rvv_pkg::vreg_t rf_wdata, rf_rdata_a, rf_rdata_b;

	rvv_dispatch u_dispatch (
		.clk          (clk),
		.resetn       (resetn),
		.pcpi_valid_i (pcpi_valid_i),
		.pcpi_insn_i  (pcpi_insn_i),
		.pcpi_wr_o    (pcpi_wr_o),
		.pcpi_rd_o    (pcpi_rd_o),
		.pcpi_wait_o  (pcpi_wait_o),
		.pcpi_ready_o (pcpi_ready_o),
		.cfg_start_o  (cfg_start),
		.lsu_start_o  (lsu_start),
		.mv_start_o   (mv_start),
		.cfg_done_i   (cfg_done),
		.lsu_done_i   (lsu_done),
		.mv_done_i    (mv_done),
		.cfg_rd_i     (vl),
		.mv_rd_i      (mv_rd),
		.busy_lsu_o   (busy_lsu)
	);

	rvv_vcfg u_vcfg (
		.clk     (clk),
		.resetn  (resetn),
		.start_i (cfg_start),
		.insn_i  (pcpi_insn_i),
		.rs1_i   (pcpi_rs1_i),
		.rs2_i   (pcpi_rs2_i),
		.done_o  (cfg_done),
		.vl_o    (vl),
		.sew_o   (sew),
		.lmul_o  (lmul)
	);

	// lsu and vmove never overlap, the owner follows the running class
	assign rf_raddr_a = busy_lsu ? lsu_raddr : mv_raddr_a;
	assign rf_we      = busy_lsu ? lsu_we : mv_we;
	assign rf_waddr   = busy_lsu ? lsu_waddr : mv_waddr;
	assign rf_wdata   = busy_lsu ? lsu_wdata : mv_wdata;

	rvv_vregs u_vregs (
		.clk       (clk),
		.we_i      (rf_we),
		.waddr_i   (rf_waddr),
		.wdata_i   (rf_wdata),
		.raddr_a_i (rf_raddr_a),
		.raddr_b_i (mv_raddr_b),
		.rdata_a_o (rf_rdata_a),
		.rdata_b_o (rf_rdata_b)
	);

	rvv_lsu u_lsu (
		.clk         (clk),
		.resetn      (resetn),
		.start_i     (lsu_start),
		.insn_i      (pcpi_insn_i),
		.base_i      (pcpi_rs1_i),
		.vl_i        (vl),
		.sew_i       (sew),
		.lmul_i      (lmul),
		.done_o      (lsu_done),
		.raddr_o     (lsu_raddr),
		.rdata_i     (rf_rdata_a),
		.we_o        (lsu_we),
		.waddr_o     (lsu_waddr),
		.wdata_o     (lsu_wdata),
		.mem_valid_o (mem_valid_o),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_wdata_o (mem_wdata_o),
		.mem_strb_o  (mem_strb_o),
		.mem_rdata_i (mem_rdata_i),
		.mem_done_i  (mem_done_i)
	);

	rvv_vmove u_vmove (
		.clk       (clk),
		.resetn    (resetn),
		.start_i   (mv_start),
		.insn_i    (pcpi_insn_i),
		.rs1_i     (pcpi_rs1_i),
		.vl_i      (vl),
		.sew_i     (sew),
		.lmul_i    (lmul),
		.done_o    (mv_done),
		.rd_o      (mv_rd),
		.raddr_a_o (mv_raddr_a),
		.raddr_b_o (mv_raddr_b),
		.rdata_a_i (rf_rdata_a),
		.rdata_b_i (rf_rdata_b),
		.we_o      (mv_we),
		.waddr_o   (mv_waddr),
		.wdata_o   (mv_wdata)
	);
endmodule

// ==== hdl/rvv_dispatch.sv ====
`include "rvv_settings.svh"

module rvv_dispatch (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 pcpi_valid_i,
	input  logic [31:0]          pcpi_insn_i,
	output logic                 pcpi_wr_o,
	output logic [`RVV_XLEN-1:0] pcpi_rd_o,
	output logic                 pcpi_wait_o,
	output logic                 pcpi_ready_o,
	output logic                 cfg_start_o,
	output logic                 lsu_start_o,
	output logic                 mv_start_o,
	input  logic                 cfg_done_i,
	input  logic                 lsu_done_i,
	input  logic                 mv_done_i,
	input  logic [`RVV_XLEN-1:0] cfg_rd_i,
	input  logic [`RVV_XLEN-1:0] mv_rd_i,
	output logic                 busy_lsu_o
);
	typedef enum logic [1:0] {IDLE, RUN, HOLD} state_e;

	state_e state;
	rvv_pkg::insn_class_e cls;
	rvv_pkg::insn_class_e cls_q; // class of the running job
	logic issue;
	logic unit_done;

	wire [6:0] opcode = pcpi_insn_i[6:0];
	wire [2:0] funct3 = pcpi_insn_i[14:12];
	wire [5:0] funct6 = pcpi_insn_i[31:26];
	wire       vm = pcpi_insn_i[25];

	// unit-stride, nf=0, unmasked, eew of 8/16/32
	wire mem_ok = funct6 == 6'b000000 && vm && pcpi_insn_i[24:20] == 5'd0
		&& (funct3 == 3'b000 || funct3 == 3'b101 || funct3 == 3'b110);

	always_comb begin
		cls = rvv_pkg::NONE;
		if (opcode == `RVV_OP_V) begin
			if (funct3 == 3'b111) begin
				if (!pcpi_insn_i[31] || pcpi_insn_i[31:30] == 2'b11
						|| pcpi_insn_i[31:25] == 7'b1000000)
					cls = rvv_pkg::CFG;
			end else if (funct6 == `RVV_F6_VMV && vm && pcpi_insn_i[24:20] == 5'd0
					&& (funct3 == 3'b000 || funct3 == 3'b100 || funct3 == 3'b011)) begin
				cls = rvv_pkg::MOVE;
			end else if (funct6 == `RVV_F6_VWXUNARY0 && vm && funct3 == 3'b010
					&& pcpi_insn_i[19:15] == 5'd0) begin
				cls = rvv_pkg::MVXS;
			end
		end else if (opcode == `RVV_OP_LOAD_FP && mem_ok) begin
			cls = rvv_pkg::LOAD;
		end else if (opcode == `RVV_OP_STORE_FP && mem_ok) begin
			cls = rvv_pkg::STORE;
		end
	end

	assign issue = state == IDLE && pcpi_valid_i && cls != rvv_pkg::NONE;
	assign cfg_start_o = issue && cls == rvv_pkg::CFG;
	assign lsu_start_o = issue && (cls == rvv_pkg::LOAD || cls == rvv_pkg::STORE);
	assign mv_start_o = issue && (cls == rvv_pkg::MOVE || cls == rvv_pkg::MVXS);
	assign busy_lsu_o = cls_q == rvv_pkg::LOAD || cls_q == rvv_pkg::STORE;

	always_comb begin
		case (cls_q)
			rvv_pkg::CFG:                 unit_done = cfg_done_i;
			rvv_pkg::LOAD, rvv_pkg::STORE: unit_done = lsu_done_i;
			rvv_pkg::MOVE, rvv_pkg::MVXS:  unit_done = mv_done_i;
			default:                      unit_done = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= IDLE;
			cls_q <= rvv_pkg::NONE;
			pcpi_wait_o <= 1'b0;
			pcpi_ready_o <= 1'b0;
			pcpi_wr_o <= 1'b0;
		end else begin
			pcpi_ready_o <= 1'b0;
			pcpi_wr_o <= 1'b0;
			case (state)
				IDLE: begin
					if (issue) begin
						state <= RUN;
						cls_q <= cls;
						pcpi_wait_o <= 1'b1;
					end
				end
				RUN: begin
					if (unit_done) begin
						state <= HOLD;
						pcpi_wait_o <= 1'b0;
						pcpi_ready_o <= 1'b1;
						pcpi_wr_o <= cls_q == rvv_pkg::CFG || cls_q == rvv_pkg::MVXS;
					end
				end
				default: begin
					if (!pcpi_valid_i)
						state <= IDLE; // core has let go of this instruction
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == RUN && unit_done)
			pcpi_rd_o <= (cls_q == rvv_pkg::CFG) ? cfg_rd_i : mv_rd_i;
	end
endmodule

// ==== hdl/rvv_lsu.sv ====
`include "rvv_settings.svh"

module rvv_lsu (
	input  logic           clk,
	input  logic           resetn,
	input  logic           start_i,
	input  logic [31:0]    insn_i,
	input  logic [31:0]    base_i,
	input  logic [31:0]    vl_i,
	input  rvv_pkg::sew_e  sew_i,
	input  rvv_pkg::lmul_e lmul_i,
	output logic           done_o,
	output logic [4:0]     raddr_o,
	input  rvv_pkg::vreg_t rdata_i,
	output logic           we_o,
	output logic [4:0]     waddr_o,
	output rvv_pkg::vreg_t wdata_o,
	output logic           mem_valid_o,
	output logic           mem_we_o,
	output logic [31:0]    mem_addr_o,
	output logic [31:0]    mem_wdata_o,
	output logic [3:0]     mem_strb_o,
	input  logic [31:0]    mem_rdata_i,
	input  logic           mem_done_i
);
	localparam int VLENB_LOG = $clog2(`RVV_VLEN / 8);

	logic                 active;  // element walk in progress
	logic                 zero_q;  // vl=0 job
	logic [31:0]          idx;     // element index
	logic [31:0]          boff;    // byte offset from base
	logic [4:0]           reg_off; // register within the group
	logic [VLENB_LOG-1:0] bsel;    // first byte of the element in its register
	logic [2:0]           ebytes;
	logic [1:0]           lane;
	logic [31:0]          elem_st;
	logic [31:0]          elem_ld;
	logic                 last;
	logic                 hs_done;

	assign mem_we_o = insn_i[5]; // STORE-FP differs from LOAD-FP in bit 5
	assign ebytes = 3'd1 << sew_i;
	assign boff = idx << sew_i;
	assign reg_off = boff[VLENB_LOG +: 5] & ((5'd1 << lmul_i) - 5'd1);
	assign bsel = boff[VLENB_LOG-1:0];
	assign last = idx == vl_i - 32'd1;
	assign hs_done = mem_valid_o && mem_done_i;

	// vd for loads, vs3 for stores, same field
	assign raddr_o = insn_i[11:7] + reg_off;
	assign waddr_o = raddr_o;

	// elements are naturally aligned, so one beat always covers one element
	assign mem_addr_o = base_i + boff;
	assign lane = mem_addr_o[1:0];
	assign mem_strb_o = 4'((5'd1 << ebytes) - 5'd1) << lane;

	assign elem_st = 32'(rdata_i >> (bsel * 8));
	assign mem_wdata_o = elem_st << (lane * 8);

	// read-modify-write of the current register
	assign elem_ld = mem_rdata_i >> (lane * 8);
	always_comb begin
		wdata_o = rdata_i;
		for (int k = 0; k < 4; k++) begin
			if (k < ebytes)
				wdata_o[(bsel + k) * 8 +: 8] = elem_ld[k * 8 +: 8];
		end
	end

	assign we_o = hs_done && !mem_we_o;
	assign done_o = zero_q || (hs_done && last);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			mem_valid_o <= 1'b0;
			zero_q <= 1'b0;
			idx <= '0;
		end else begin
			zero_q <= start_i && vl_i == 32'd0;
			if (start_i) begin
				idx <= '0;
				active <= vl_i != 32'd0;
				mem_valid_o <= vl_i != 32'd0;
			end else if (mem_valid_o) begin
				if (mem_done_i) begin
					mem_valid_o <= 1'b0; // one idle cycle between requests
					if (last)
						active <= 1'b0;
					else
						idx <= idx + 32'd1;
				end
			end else if (active) begin
				mem_valid_o <= 1'b1;
			end
		end
	end
endmodule

// ==== hdl/rvv_pkg.sv ====
`include "rvv_settings.svh"

package rvv_pkg;

	typedef logic [`RVV_VLEN-1:0] vreg_t; // one whole vector register

	// vsew encoding, anything above E32 is illegal here
	typedef enum logic [2:0] {
		E8  = 3'b000,
		E16 = 3'b001,
		E32 = 3'b010
	} sew_e;

	typedef enum logic [2:0] {
		M1       = 3'b000,
		M2       = 3'b001,
		M4       = 3'b010,
		M8       = 3'b011,
		RESERVED = 3'b100 // this and above: reserved or fractional
	} lmul_e;

	typedef struct packed {
		logic        vill;
		logic [22:0] reserved;
		logic        vma;
		logic        vta;
		logic [2:0]  vsew;
		logic [2:0]  vlmul;
	} vtype_t;

	// which unit an instruction goes to
	typedef enum logic [2:0] {
		NONE,
		CFG,
		LOAD,
		STORE,
		MOVE,
		MVXS
	} insn_class_e;

endpackage

// ==== hdl/rvv_settings.svh ====
`ifndef RVV_SETTINGS_SVH
`define RVV_SETTINGS_SVH

// vector register geometry
`define RVV_VLEN 128
`define RVV_NREGS 32
`define RVV_XLEN 32

// major opcodes
`define RVV_OP_V 7'b1010111
`define RVV_OP_LOAD_FP 7'b0000111
`define RVV_OP_STORE_FP 7'b0100111

// funct6 of the move group and of vmv.x.s
`define RVV_F6_VMV 6'b010111
`define RVV_F6_VWXUNARY0 6'b010000

`endif

// ==== hdl/rvv_vcfg.sv ====
`include "rvv_settings.svh"

module rvv_vcfg (
	input  logic           clk,
	input  logic           resetn,
	input  logic           start_i,
	input  logic [31:0]    insn_i,
	input  logic [31:0]    rs1_i,
	input  logic [31:0]    rs2_i,
	output logic           done_o,
	output logic [31:0]    vl_o,
	output rvv_pkg::sew_e  sew_o,
	output rvv_pkg::lmul_e lmul_o
);
	rvv_pkg::vtype_t vtype_q;
	rvv_pkg::vtype_t vtype_new;
	logic [31:0] vlmax;
	logic [31:0] avl;
	logic [31:0] vl_new;
	logic legal;

	wire is_vsetvl = insn_i[31:25] == 7'b1000000;
	wire is_vsetivli = insn_i[31:30] == 2'b11;
	wire [4:0] rs1_idx = insn_i[19:15]; // also the uimm of vsetivli
	wire [4:0] rd_idx = insn_i[11:7];

	always_comb begin
		// zimm low byte holds vma, vta, vsew and vlmul for both immediate forms
		vtype_new = is_vsetvl ? rs2_i : {24'b0, insn_i[27:20]};
		legal = !vtype_new.vill && vtype_new.vsew <= 3'(rvv_pkg::E32)
			&& vtype_new.vlmul < 3'(rvv_pkg::RESERVED);
		vlmax = (`RVV_VLEN >> (vtype_new.vsew + 3)) << vtype_new.vlmul;

		if (is_vsetivli)
			avl = {27'b0, rs1_idx};
		else if (rs1_idx != 5'd0)
			avl = rs1_i;
		else if (rd_idx != 5'd0)
			avl = '1; // ask for vlmax
		else
			avl = vl_o; // vtype change only

		vl_new = legal ? ((avl < vlmax) ? avl : vlmax) : 32'd0;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			vtype_q <= '{vill: 1'b1, default: '0};
			vl_o <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= start_i;
			if (start_i) begin
				vtype_q <= legal ? vtype_new : '{vill: 1'b1, default: '0};
				vl_o <= vl_new;
			end
		end
	end

	assign sew_o = rvv_pkg::sew_e'(vtype_q.vsew);
	assign lmul_o = rvv_pkg::lmul_e'(vtype_q.vlmul);
endmodule

// ==== hdl/rvv_vmove.sv ====
`include "rvv_settings.svh"

module rvv_vmove (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 start_i,
	input  logic [31:0]          insn_i,
	input  logic [31:0]          rs1_i,
	input  logic [31:0]          vl_i,
	input  rvv_pkg::sew_e        sew_i,
	input  rvv_pkg::lmul_e       lmul_i,
	output logic                 done_o,
	output logic [`RVV_XLEN-1:0] rd_o,
	output logic [4:0]           raddr_a_o,
	output logic [4:0]           raddr_b_o,
	input  rvv_pkg::vreg_t       rdata_a_i,
	input  rvv_pkg::vreg_t       rdata_b_i,
	output logic                 we_o,
	output logic [4:0]           waddr_o,
	output rvv_pkg::vreg_t       wdata_o
);
	localparam int VLENB = `RVV_VLEN / 8;
	localparam int VLENB_LOG = $clog2(VLENB);

	logic           active;    // vmv.v.* walk
	logic           xs_q;      // vmv.x.s result cycle
	logic [4:0]     r_q;
	logic [4:0]     grp_off;
	logic [31:0]    rem_bytes; // bytes below vl from this register on
	logic [31:0]    scalar;
	logic           last;
	rvv_pkg::vreg_t src;

	wire [2:0] funct3 = insn_i[14:12];
	wire [4:0] vd = insn_i[11:7];
	wire       is_xs = funct3 == 3'b010;

	assign grp_off = r_q & ((5'd1 << lmul_i) - 5'd1);
	assign rem_bytes = (vl_i << sew_i) - (32'(r_q) << VLENB_LOG);
	assign last = rem_bytes <= 32'(VLENB);

	assign raddr_a_o = insn_i[19:15] + grp_off; // vs1 group
	assign raddr_b_o = is_xs ? insn_i[24:20] : vd + grp_off;
	assign waddr_o = vd + grp_off;
	assign we_o = active;
	assign done_o = xs_q || (active && last);

	// simm5 for .vi, rs1 for .vx
	assign scalar = (funct3 == 3'b011) ? {{27{insn_i[19]}}, insn_i[19:15]} : rs1_i;

	always_comb begin
		case (sew_i)
			rvv_pkg::E8:  src = {(VLENB){scalar[7:0]}};
			rvv_pkg::E16: src = {(VLENB / 2){scalar[15:0]}};
			default:      src = {(VLENB / 4){scalar}};
		endcase
		if (funct3 == 3'b000)
			src = rdata_a_i; // vmv.v.v
		// tail bytes keep the old vd
		for (int b = 0; b < VLENB; b++)
			wdata_o[b * 8 +: 8] = (b < rem_bytes) ? src[b * 8 +: 8] : rdata_b_i[b * 8 +: 8];
	end

	always_comb begin
		case (sew_i)
			rvv_pkg::E8:  rd_o = {{24{rdata_b_i[7]}}, rdata_b_i[7:0]};
			rvv_pkg::E16: rd_o = {{16{rdata_b_i[15]}}, rdata_b_i[15:0]};
			default:      rd_o = rdata_b_i[31:0];
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			xs_q <= 1'b0;
			r_q <= '0;
		end else begin
			xs_q <= start_i && is_xs;
			if (start_i) begin
				active <= !is_xs;
				r_q <= '0;
			end else if (active) begin
				if (last)
					active <= 1'b0;
				else
					r_q <= r_q + 5'd1;
			end
		end
	end
endmodule

// ==== hdl/rvv_vregs.sv ====
`include "rvv_settings.svh"

module rvv_vregs (
	input  logic           clk,
	input  logic           we_i,
	input  logic [4:0]     waddr_i,
	input  rvv_pkg::vreg_t wdata_i,
	input  logic [4:0]     raddr_a_i,
	input  logic [4:0]     raddr_b_i,
	output rvv_pkg::vreg_t rdata_a_o,
	output rvv_pkg::vreg_t rdata_b_o
);
	rvv_pkg::vreg_t regs [`RVV_NREGS];

	// power-up contents are zero, tail elements read back defined
	initial begin
		for (int i = 0; i < `RVV_NREGS; i++)
			regs[i] = '0;
	end

	always @(posedge clk) begin
		if (we_i)
			regs[waddr_i] <= wdata_i;
	end

	assign rdata_a_o = regs[raddr_a_i];
	assign rdata_b_o = regs[raddr_b_i];
endmodule

// ==== project.f ====
+incdir+hdl
hdl/rvv_pkg.sv
hdl/rvv_vcfg.sv
hdl/rvv_vregs.sv
hdl/rvv_lsu.sv
hdl/rvv_vmove.sv
hdl/rvv_dispatch.sv
hdl/rvv_coproc.sv
dv/rvv_checker.sv
dv/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the vector coprocessor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f project.f --top-module tb_top -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
	echo "test failed, see sim.log"
	exit 1
fi
echo "test passed"
exit 0
